// File: source/uart_frame_consts.svh
// --------------------------------------------------
// uart framing link constants
// bit timing, payload limit and the delimiter byte
// --------------------------------------------------
`ifndef UART_FRAME_CONSTS_SVH
`define UART_FRAME_CONSTS_SVH

// clocks per serial bit, kept small for simulation
`define UF_CLK_PER_BIT 8

// largest payload a frame may carry
`define UF_MAX_LEN 16

// length field width, holds 0 to UF_MAX_LEN
`define UF_LEN_W 5

// ascii '&', sent twice to open and twice to close
`define UF_DELIM 8'h26

`endif

// File: source/uart_frame_pkg.sv
// --------------------------------------------------
// uart framing link types
// frame and received byte structs, FSM state enums
// --------------------------------------------------
`default_nettype none

`include "uart_frame_consts.svh"

package uart_frame_pkg;

	// payload[0] goes out first on the line
	typedef struct packed {
		logic [`UF_MAX_LEN-1:0][7:0] payload;
		logic [`UF_LEN_W-1:0]        len;
	} frame_t;

	// one byte from the sampler plus its stop bit check
	typedef struct packed {
		logic [7:0] data;
		logic       stop_err;
	} rx_byte_t;

	typedef enum logic [2:0] {
		tx_idle, tx_open1, tx_open2, tx_payload, tx_close1, tx_close2
	} tx_state_e;

	typedef enum logic [1:0] {
		rx_hunt, rx_open2, rx_payload, rx_close2
	} rx_state_e;

	// per-bit states, same for serializer and sampler
	typedef enum logic [1:0] {
		line_idle, line_start, line_data, line_stop
	} line_state_e;

endpackage

`default_nettype wire

// File: source/uart_tx.sv
// --------------------------------------------------
// uart serializer
// start bit, eight data bits lsb first, one stop bit
// --------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

`include "uart_frame_consts.svh"

module uart_tx (
	input  wire       sys_clk,
	input  wire       sys_rst_n,
	input  wire       byte_req,
	input  wire [7:0] byte_data,
	output logic      tx,
	output logic      byte_done
);
	import uart_frame_pkg::*;

	localparam int cnt_w = $clog2(`UF_CLK_PER_BIT);
	localparam logic [cnt_w-1:0] bit_last = cnt_w'(`UF_CLK_PER_BIT - 1);

	line_state_e      state;
	logic [cnt_w-1:0] clk_cnt;
	logic [2:0]       bit_cnt;
	logic [7:0]       data_q;

	// byte is taken only when the line is free
	always_ff @(posedge sys_clk) begin
		if (state == line_idle && byte_req)
			data_q <= byte_data;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= line_idle;
			clk_cnt   <= '0;
			bit_cnt   <= '0;
			tx        <= 1'b1;
			byte_done <= 1'b0;
		end else begin
			byte_done <= 1'b0;
			case (state)
				line_idle: begin
					clk_cnt <= '0;
					if (byte_req) begin
						tx    <= 1'b0;
						state <= line_start;
					end
				end
				line_start: begin
					clk_cnt <= clk_cnt + 1'b1;
					if (clk_cnt == bit_last) begin
						clk_cnt <= '0;
						bit_cnt <= '0;
						tx      <= data_q[0];
						state   <= line_data;
					end
				end
				line_data: begin
					clk_cnt <= clk_cnt + 1'b1;
					if (clk_cnt == bit_last) begin
						clk_cnt <= '0;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7) begin
							tx    <= 1'b1;
							state <= line_stop;
						end else begin
							tx <= data_q[bit_cnt + 3'd1];
						end
					end
				end
				line_stop: begin
					clk_cnt <= clk_cnt + 1'b1;
					// done lands in the cycle after the stop bit
					if (clk_cnt == bit_last) begin
						clk_cnt   <= '0;
						byte_done <= 1'b1;
						state     <= line_idle;
					end
				end
				default: state <= line_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/uart_rx.sv
// --------------------------------------------------
// uart sampler
// synchronizes the line, samples each bit at mid-bit
// and flags a low stop bit
// --------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

`include "uart_frame_consts.svh"

module uart_rx (
	input  wire                      sys_clk,
	input  wire                      sys_rst_n,
	input  wire                      rx,
	output uart_frame_pkg::rx_byte_t rx_byte,
	output logic                     rx_vld
);
	import uart_frame_pkg::*;

	localparam int cnt_w = $clog2(`UF_CLK_PER_BIT);
	localparam logic [cnt_w-1:0] bit_last = cnt_w'(`UF_CLK_PER_BIT - 1);
	localparam logic [cnt_w-1:0] bit_mid  = cnt_w'(`UF_CLK_PER_BIT / 2 - 1);

	line_state_e      state;
	logic [cnt_w-1:0] clk_cnt;
	logic [2:0]       bit_cnt;
	logic [7:0]       shift;
	logic             rx_s1;
	logic             rx_s2;
	logic             rx_d;
	logic             fall;

	// two flop synchronizer, rx_d only for edge detect
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_s1 <= 1'b1;
			rx_s2 <= 1'b1;
			rx_d  <= 1'b1;
		end else begin
			rx_s1 <= rx;
			rx_s2 <= rx_s1;
			rx_d  <= rx_s2;
		end
	end

	assign fall = rx_d & ~rx_s2;

	always_ff @(posedge sys_clk) begin
		if (state == line_data && clk_cnt == bit_last)
			shift <= {rx_s2, shift[7:1]};
		if (state == line_stop && clk_cnt == bit_last) begin
			rx_byte.data     <= shift;
			rx_byte.stop_err <= ~rx_s2;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= line_idle;
			clk_cnt <= '0;
			bit_cnt <= '0;
			rx_vld  <= 1'b0;
		end else begin
			rx_vld  <= 1'b0;
			clk_cnt <= clk_cnt + 1'b1;
			case (state)
				line_idle: begin
					clk_cnt <= '0;
					if (fall)
						state <= line_start;
				end
				line_start: begin
					// start bit high again at mid-bit means a glitch
					if (clk_cnt == bit_mid) begin
						clk_cnt <= '0;
						bit_cnt <= '0;
						state   <= rx_s2 ? line_idle : line_data;
					end
				end
				line_data: begin
					if (clk_cnt == bit_last) begin
						clk_cnt <= '0;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= line_stop;
					end
				end
				line_stop: begin
					// back to idle at mid-stop, ready for the next edge
					if (clk_cnt == bit_last) begin
						rx_vld <= 1'b1;
						state  <= line_idle;
					end
				end
				default: state <= line_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/frame_tx_ctrl.sv
// --------------------------------------------------
// transmit framer
// sends &&, the payload bytes and && to the serializer
// --------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

`include "uart_frame_consts.svh"

module frame_tx_ctrl (
	input  wire                    sys_clk,
	input  wire                    sys_rst_n,
	input  wire uart_frame_pkg::frame_t tx_frame,
	input  wire                    tx_req,
	input  wire                    byte_done,
	output logic                   tx_busy,
	output logic                   tx_done,
	output logic                   byte_req,
	output logic [7:0]             byte_data
);
	import uart_frame_pkg::*;

	tx_state_e            state;
	frame_t               frame_q;
	logic [`UF_LEN_W-1:0] idx;

	// busy also covers the done cycle so a request there is ignored
	assign tx_busy = (state != tx_idle) || tx_done;

	always_ff @(posedge sys_clk) begin
		if (!tx_busy && tx_req)
			frame_q <= tx_frame;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= tx_idle;
			idx       <= '0;
			tx_done   <= 1'b0;
			byte_req  <= 1'b0;
			byte_data <= `UF_DELIM;
		end else begin
			byte_req <= 1'b0;
			tx_done  <= 1'b0;
			case (state)
				tx_idle: begin
					if (!tx_busy && tx_req) begin
						byte_req  <= 1'b1;
						byte_data <= `UF_DELIM;
						state     <= tx_open1;
					end
				end
				tx_open1: begin
					if (byte_done) begin
						byte_req  <= 1'b1;
						byte_data <= `UF_DELIM;
						state     <= tx_open2;
					end
				end
				tx_open2: begin
					if (byte_done) begin
						byte_req <= 1'b1;
						// empty frame goes straight to the closing pair
						if (frame_q.len == '0) begin
							byte_data <= `UF_DELIM;
							state     <= tx_close1;
						end else begin
							byte_data <= frame_q.payload[0];
							idx       <= `UF_LEN_W'(1);
							state     <= tx_payload;
						end
					end
				end
				tx_payload: begin
					if (byte_done) begin
						byte_req <= 1'b1;
						if (idx == frame_q.len) begin
							byte_data <= `UF_DELIM;
							state     <= tx_close1;
						end else begin
							byte_data <= frame_q.payload[idx];
							idx       <= idx + 1'b1;
						end
					end
				end
				tx_close1: begin
					if (byte_done) begin
						byte_req  <= 1'b1;
						byte_data <= `UF_DELIM;
						state     <= tx_close2;
					end
				end
				tx_close2: begin
					if (byte_done) begin
						tx_done <= 1'b1;
						state   <= tx_idle;
					end
				end
				default: state <= tx_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/frame_rx_ctrl.sv
// --------------------------------------------------
// receive deframer
// hunts for &&, collects payload up to the next &&
// drops overlong frames and stop bit errors
// --------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

`include "uart_frame_consts.svh"

module frame_rx_ctrl (
	input  wire                           sys_clk,
	input  wire                           sys_rst_n,
	input  wire uart_frame_pkg::rx_byte_t rx_byte,
	input  wire                           rx_vld,
	output uart_frame_pkg::frame_t        rx_frame,
	output logic                          rx_busy,
	output logic                          rx_done,
	output logic                          rx_error
);
	import uart_frame_pkg::*;

	localparam logic [`UF_LEN_W-1:0] max_len = `UF_MAX_LEN;

	rx_state_e                   state;
	logic [`UF_LEN_W-1:0]        cnt;
	logic [`UF_MAX_LEN-1:0][7:0] buf_q;
	logic                        is_delim;
	logic                        good_delim;

	assign is_delim   = (rx_byte.data == `UF_DELIM);
	assign good_delim = is_delim && !rx_byte.stop_err;
	assign rx_busy    = (state == rx_payload) || (state == rx_close2);

	// working buffer, cleared as each frame opens
	always_ff @(posedge sys_clk) begin
		if (rx_vld && state == rx_open2)
			buf_q <= '0;
		else if (rx_vld && state == rx_payload && !is_delim && cnt != max_len)
			buf_q[cnt] <= rx_byte.data;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= rx_hunt;
			cnt      <= '0;
			rx_frame <= '0;
			rx_done  <= 1'b0;
			rx_error <= 1'b0;
		end else begin
			rx_done  <= 1'b0;
			rx_error <= 1'b0;
			if (rx_vld) begin
				case (state)
					rx_hunt: begin
						if (good_delim)
							state <= rx_open2;
					end
					rx_open2: begin
						cnt   <= '0;
						state <= good_delim ? rx_payload : rx_hunt;
					end
					rx_payload: begin
						if (rx_byte.stop_err || (!is_delim && cnt == max_len)) begin
							rx_error <= 1'b1;
							state    <= rx_hunt;
						end else if (is_delim) begin
							state <= rx_close2;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
					rx_close2: begin
						state <= rx_hunt;
						if (good_delim) begin
							rx_frame.payload <= buf_q;
							rx_frame.len     <= cnt;
							rx_done          <= 1'b1;
						end else begin
							rx_error <= 1'b1;
						end
					end
					default: state <= rx_hunt;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: source/uart_frame_top.sv
// --------------------------------------------------
// uart framing link top
// framer and serializer on tx, sampler and deframer on rx
// --------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

module uart_frame_top (
	input  wire                         sys_clk,
	input  wire                         sys_rst_n,
	input  wire uart_frame_pkg::frame_t tx_frame,
	input  wire                         tx_req,
	output wire                         tx_busy,
	output wire                         tx_done,
	output wire uart_frame_pkg::frame_t rx_frame,
	output wire                         rx_busy,
	output wire                         rx_done,
	output wire                         rx_error,
	input  wire                         uart_rx_port,
	output wire                         uart_tx_port
);
	import uart_frame_pkg::*;

	wire           byte_req;
	wire           byte_done;
	wire     [7:0] byte_data;
	wire rx_byte_t rx_byte;
	wire           rx_vld;

	// transmit path
	frame_tx_ctrl u_frame_tx_ctrl (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_frame  (tx_frame),
		.tx_req    (tx_req),
		.byte_done (byte_done),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.byte_req  (byte_req),
		.byte_data (byte_data)
	);

	uart_tx u_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.byte_req  (byte_req),
		.byte_data (byte_data),
		.tx        (uart_tx_port),
		.byte_done (byte_done)
	);

	// receive path
	uart_rx u_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx        (uart_rx_port),
		.rx_byte   (rx_byte),
		.rx_vld    (rx_vld)
	);

	frame_rx_ctrl u_frame_rx_ctrl (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_byte   (rx_byte),
		.rx_vld    (rx_vld),
		.rx_frame  (rx_frame),
		.rx_busy   (rx_busy),
		.rx_done   (rx_done),
		.rx_error  (rx_error)
	);

endmodule

`default_nettype wire

// File: testbench/uart_frame_assert.sv
// --------------------------------------------------
// uart framing link assertions
// handshake and idle line rules, bound to the top
// --------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

module uart_frame_assert (
	input wire sys_clk,
	input wire sys_rst_n,
	input wire tx_req,
	input wire tx_busy,
	input wire tx_done,
	input wire rx_done,
	input wire rx_error,
	input wire uart_tx_port
);
	// failed checks so far
	int fail_cnt = 0;

	// a request in the done cycle is not taken, so no busy after it
	a_req_done: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_req && tx_done |=> !tx_busy)
	else begin
		fail_cnt++;
		$error("request accepted in a cycle where tx_done was high");
	end

	a_done_busy: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_done |-> $past(tx_busy))
	else begin
		fail_cnt++;
		$error("tx_done without tx_busy in the previous cycle");
	end

	a_rx_end: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!(rx_done && rx_error))
	else begin
		fail_cnt++;
		$error("rx_done and rx_error in the same cycle");
	end

	// line idles high while nothing is being sent
	a_line_idle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!tx_busy |-> uart_tx_port)
	else begin
		fail_cnt++;
		$error("serial line low while the transmitter is idle");
	end

endmodule

bind uart_frame_top uart_frame_assert i_assert (
	.sys_clk      (sys_clk),
	.sys_rst_n    (sys_rst_n),
	.tx_req       (tx_req),
	.tx_busy      (tx_busy),
	.tx_done      (tx_done),
	.rx_done      (rx_done),
	.rx_error     (rx_error),
	.uart_tx_port (uart_tx_port)
);

`default_nettype wire

// File: testbench/tb_uart_frame.sv
// --------------------------------------------------
// uart framing link testbench
// loopback and driven serial streams, checked against
// a reference model of the frame rules
// --------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

`include "uart_frame_consts.svh"

module tb_uart_frame;
	import uart_frame_pkg::*;

	localparam int n_frames  = 27;
	localparam int byte_clks = 10 * `UF_CLK_PER_BIT;
	localparam int wd_cycles = (n_frames + 4) * (`UF_MAX_LEN + 4) * byte_clks * 2;

	// reference model states
	localparam int m_hunt    = 0;
	localparam int m_open2   = 1;
	localparam int m_payload = 2;
	localparam int m_close2  = 3;

	// one expected frame end, either a completed frame or a drop
	typedef struct packed {
		logic   is_err;
		frame_t frame;
	} rx_event_t;

	logic        sys_clk;
	logic        sys_rst_n;
	frame_t      tx_frame;
	logic        tx_req;
	logic        tx_busy;
	logic        tx_done;
	frame_t      rx_frame;
	logic        rx_busy;
	logic        rx_done;
	logic        rx_error;
	logic        uart_rx_port;
	logic        uart_tx_port;
	logic        use_loop;
	logic        drv_line;
	logic [31:0] lcg_state;
	rx_event_t   exp_q[$];
	string       test_name;
	int          err_cnt = 0;
	int          evt_cnt = 0;
	int          tx_done_cnt = 0;
	int          m_state;
	int          m_cnt;
	frame_t      m_frame;

	uart_frame_top i_dut (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_frame     (tx_frame),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_frame     (rx_frame),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.rx_error     (rx_error),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	// receive line from the transmitter or from the serial driver
	assign uart_rx_port = use_loop ? uart_tx_port : drv_line;

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// printable ascii, the delimiter skipped
	function automatic logic [7:0] rand_char();
		logic [7:0] c;
		c = 8'h21 + 8'((lcg_next() >> 16) % 32'd93);
		if (c >= `UF_DELIM)
			c = c + 8'd1;
		return c;
	endfunction

	// unused payload bytes stay zero, as the receive buffer does
	function automatic frame_t rand_frame(input int len);
		frame_t f;
		f     = '0;
		f.len = `UF_LEN_W'(len);
		for (int i = 0; i < len; i++)
			f.payload[4'(i)] = rand_char();
		return f;
	endfunction

	// frame rules applied to one received byte
	function automatic void model_byte(input logic [7:0] data, input logic stop_err);
		rx_event_t ev;
		logic      delim;
		logic      good;
		delim     = (data == `UF_DELIM);
		good      = delim && !stop_err;
		ev.is_err = 1'b1;
		ev.frame  = '0;
		case (m_state)
			m_hunt: begin
				if (good)
					m_state = m_open2;
			end
			m_open2: begin
				m_state = good ? m_payload : m_hunt;
				m_cnt   = 0;
				m_frame = '0;
			end
			m_payload: begin
				if (stop_err || (!delim && m_cnt == `UF_MAX_LEN)) begin
					exp_q.push_back(ev);
					m_state = m_hunt;
				end else if (delim) begin
					m_state = m_close2;
				end else begin
					m_frame.payload[4'(m_cnt)] = data;
					m_cnt++;
				end
			end
			default: begin
				m_state = m_hunt;
				if (good) begin
					m_frame.len = `UF_LEN_W'(m_cnt);
					ev.is_err   = 1'b0;
					ev.frame    = m_frame;
				end
				exp_q.push_back(ev);
			end
		endcase
	endfunction

	task automatic drive_bit(input logic b);
		drv_line = b;
		repeat (`UF_CLK_PER_BIT) @(posedge sys_clk);
		#1;
	endtask

	// start, data lsb first, stop, then one idle bit
	task automatic put_byte(input logic [7:0] data, input logic stop_err);
		logic busy_exp;
		model_byte(data, stop_err);
		// frame open from the second opening delimiter to its end
		busy_exp = (m_state == m_payload) || (m_state == m_close2);
		drive_bit(1'b0);
		for (int i = 0; i < 8; i++)
			drive_bit(data[i]);
		drive_bit(!stop_err);
		drive_bit(1'b1);
		assert (rx_busy == busy_exp) else begin
			err_cnt++;
			$display("[FAIL] %s rx_busy expected %0b actual %0b",
				test_name, busy_exp, rx_busy);
		end
	endtask

	task automatic put_delims();
		put_byte(`UF_DELIM, 1'b0);
		put_byte(`UF_DELIM, 1'b0);
	endtask

	task automatic put_frame(input frame_t f);
		put_delims();
		for (int i = 0; i < int'(f.len); i++)
			put_byte(f.payload[4'(i)], 1'b0);
		put_delims();
	endtask

	task automatic expect_frame(input frame_t f);
		rx_event_t ev;
		ev.is_err = 1'b0;
		ev.frame  = f;
		exp_q.push_back(ev);
	endtask

	task automatic pulse_req(input frame_t f);
		tx_frame = f;
		tx_req   = 1'b1;
		@(posedge sys_clk);
		#1;
		tx_req = 1'b0;
	endtask

	task automatic wait_tx_done(input int count_before);
		while (tx_done_cnt == count_before) begin
			@(posedge sys_clk);
			#1;
		end
	endtask

	task automatic wait_events();
		while (exp_q.size() != 0) begin
			@(posedge sys_clk);
			#1;
		end
	endtask

	// loopback, the receiver must return the frame unchanged
	task automatic send_frame(input frame_t f);
		int base;
		base = tx_done_cnt;
		assert (!tx_busy) else begin
			err_cnt++;
			$display("test %s: transmitter still busy before a new request", test_name);
		end
		expect_frame(f);
		pulse_req(f);
		wait_tx_done(base);
		wait_events();
	endtask

	task automatic check_tx_done(input int exp_cnt);
		assert (tx_done_cnt == exp_cnt) else begin
			err_cnt++;
			$display("[FAIL] %s tx_done count expected %0d actual %0d",
				test_name, exp_cnt, tx_done_cnt);
		end
	endtask

	always @(posedge sys_clk) begin
		if (sys_rst_n && tx_done)
			tx_done_cnt++;
	end

	// every frame end is compared with the oldest expected one
	always @(posedge sys_clk) begin : check_rx
		rx_event_t ev;
		if (sys_rst_n && (rx_done || rx_error)) begin
			evt_cnt++;
			assert (exp_q.size() != 0) else begin
				err_cnt++;
				$display("test %s: receiver ended a frame that was not expected", test_name);
			end
			if (exp_q.size() != 0) begin
				ev = exp_q.pop_front();
				assert (rx_done != rx_error && rx_error == ev.is_err) else begin
					err_cnt++;
					if (ev.is_err)
						$display("test %s: frame completed where a drop was expected", test_name);
					else
						$display("test %s: frame dropped where a completed frame was expected",
							test_name);
				end
				if (rx_done && !ev.is_err) begin
					assert (rx_frame.len == ev.frame.len) else begin
						err_cnt++;
						$display("[FAIL] %s len expected %0d actual %0d",
							test_name, ev.frame.len, rx_frame.len);
					end
					assert (rx_frame.payload == ev.frame.payload) else begin
						err_cnt++;
						$display("[FAIL] %s payload expected %h actual %h",
							test_name, ev.frame.payload, rx_frame.payload);
					end
				end
			end
		end
	end

	initial begin
		frame_t f;
		int     len;
		int     base;
		sys_rst_n = 1'b0;
		tx_frame  = '0;
		tx_req    = 1'b0;
		use_loop  = 1'b1;
		drv_line  = 1'b1;
		lcg_state = 32'd44359;
		m_state   = m_hunt;
		m_cnt     = 0;
		m_frame   = '0;
		test_name = "reset";
		repeat (3) @(posedge sys_clk);
		#1;
		sys_rst_n = 1'b1;
		repeat (2) @(posedge sys_clk);
		#1;

		test_name = "loopback_single";
		send_frame(rand_frame(5));
		check_tx_done(1);

		// first frame empty, second full length
		test_name = "loopback_random";
		for (int k = 0; k < 20; k++) begin
			if (k == 0)
				len = 0;
			else if (k == 1)
				len = `UF_MAX_LEN;
			else
				len = int'((lcg_next() >> 16) % 32'd17);
			send_frame(rand_frame(len));
		end
		check_tx_done(21);

		// second request lands mid-frame and must be dropped
		test_name = "busy_ignore";
		base = tx_done_cnt;
		f    = rand_frame(8);
		expect_frame(f);
		pulse_req(f);
		repeat (20) @(posedge sys_clk);
		#1;
		assert (tx_busy) else begin
			err_cnt++;
			$display("test %s: transmitter not busy in the middle of a frame", test_name);
		end
		pulse_req(rand_frame(3));
		// a request in the done cycle itself is dropped too
		while (!tx_done) begin
			@(posedge sys_clk);
			#1;
		end
		pulse_req(rand_frame(2));
		wait_events();
		repeat ((`UF_MAX_LEN + 4) * byte_clks) @(posedge sys_clk);
		#1;
		check_tx_done(base + 1);

		use_loop = 1'b0;
		repeat (byte_clks) @(posedge sys_clk);
		#1;

		// lone delimiter among noise does not open a frame
		test_name = "leading_noise";
		repeat (5)
			put_byte(rand_char(), 1'b0);
		put_byte(`UF_DELIM, 1'b0);
		put_byte(rand_char(), 1'b0);
		put_frame(rand_frame(6));
		wait_events();

		test_name = "overlong";
		put_delims();
		repeat (`UF_MAX_LEN + 1)
			put_byte(rand_char(), 1'b0);
		put_frame(rand_frame(4));
		wait_events();

		test_name = "stop_error";
		put_delims();
		put_byte(rand_char(), 1'b0);
		put_byte(rand_char(), 1'b0);
		put_byte(rand_char(), 1'b1);
		put_byte(rand_char(), 1'b0);
		put_delims();
		wait_events();
		repeat (4 * byte_clks) @(posedge sys_clk);
		#1;

		assert (exp_q.size() == 0) else begin
			err_cnt++;
			$display("expected frame ends still pending at the end of the run");
		end
		err_cnt = err_cnt + i_dut.i_assert.fail_cnt;
		$display("frame ends checked: %0d, error count: %0d", evt_cnt, err_cnt);
		if (err_cnt == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// bound on the longest possible length of all tests
	initial begin
		repeat (wd_cycles) @(posedge sys_clk);
		$display("timeout after %0d clock cycles, the run did not finish", wd_cycles);
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+source
source/uart_frame_pkg.sv
source/uart_tx.sv
source/uart_rx.sv
source/frame_tx_ctrl.sv
source/frame_rx_ctrl.sv
source/uart_frame_top.sv
testbench/uart_frame_assert.sv
testbench/tb_uart_frame.sv

// File: Makefile
# Verilator build and run of the uart framing link testbench

VERILATOR ?= verilator
TOP       ?= tb_uart_frame
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := source/uart_frame_consts.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Errors found" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "No errors" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
